/* decoder_top.f */
+incdir+hw
+incdir+tests
hw/decoder_pkg.sv
hw/imm_gen.sv
hw/inst_decoder.sv
hw/decode_queue.sv
hw/operand_issue.sv
hw/decoder_top.sv
tests/decoder_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the decode front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f decoder_top.f \
    --top-module decoder_tb -o decoder_sim

./obj_dir/decoder_sim | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
exit 0

/* tests/decoder_ref.svh */
`ifndef DECODER_REF_SVH
`define DECODER_REF_SVH

// Register file model returns the index in every byte, x0 included
function automatic logic [63:0] reg_value(input logic [4:0] idx);
    return {8{3'b000, idx}};
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
endfunction

// ALU operation selected by funct3 in the OP and OP-IMM groups
function automatic alu_op_e alu_from_f3(input logic [2:0] f3);
    case (f3)
        3'd0: return ALU_ADD;
        3'd1: return ALU_SLL;
        3'd2, 3'd3: return ALU_SLT;
        3'd4: return ALU_XOR;
        3'd5: return ALU_SRL;
        3'd6: return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

function automatic issue_t ref_decode(input logic [31:0] inst, input logic [47:0] pc);
    issue_t r;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [63:0] i_imm;
    logic [63:0] s_imm;
    logic [63:0] b_imm;
    logic [63:0] u_imm;
    logic [63:0] j_imm;
    r = '0;
    f3 = inst[14:12];
    f7 = inst[31:25];
    i_imm = {{52{inst[31]}}, inst[31:20]};
    s_imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    b_imm = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    u_imm = {{32{inst[31]}}, inst[31:12], 12'h000};
    j_imm = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    r.dec.pc = pc;
    r.dec.rd = inst[11:7];
    r.dec.rs1 = inst[19:15];
    r.dec.rs2 = inst[24:20];
    r.src1 = reg_value(inst[19:15]);
    r.src2 = reg_value(inst[24:20]);
    case (inst[6:0])
        7'h37, 7'h17: begin
            r.dec.alu_op = (inst[6:0] == 7'h37) ? ALU_LUI : ALU_AUIPC;
            r.dec.imm = u_imm;
        end
        7'h6f: begin
            r.dec.cx_op = CX_JAL;
            r.dec.imm = j_imm;
        end
        7'h67: begin
            r.dec.cx_op = CX_JALR;
            r.dec.imm = i_imm;
        end
        7'h63: if (f3 != 3'd2 && f3 != 3'd3) begin
            if (f3 == 3'd0) r.dec.cx_op = CX_BEQ;
            else if (f3 == 3'd1) r.dec.cx_op = CX_BNE;
            else r.dec.cx_op = f3[0] ? CX_BGE : CX_BLT;
            r.dec.is_unsigned = f3[1];
            r.dec.imm = b_imm;
        end
        7'h03: if (f3 != 3'd7) begin
            r.dec.is_load = 1'b1;
            r.dec.ls_size = ls_size_e'(f3[1:0]);
            r.dec.is_unsigned = f3[2];
            r.dec.imm = i_imm;
        end
        7'h23: if (f3 < 3'd4) begin
            r.dec.is_store = 1'b1;
            r.dec.ls_size = ls_size_e'(f3[1:0]);
            r.dec.imm = s_imm;
        end
        7'h13: begin
            if (f3 == 3'd1) r.dec.alu_op = (f7[6:1] == 6'h00) ? ALU_SLL : ALU_NONE;
            else if (f3 == 3'd5 && f7[6:1] == 6'h00) r.dec.alu_op = ALU_SRL;
            else if (f3 == 3'd5 && f7[6:1] == 6'h10) r.dec.alu_op = ALU_SRA;
            else if (f3 != 3'd5) r.dec.alu_op = alu_from_f3(f3);
            r.dec.is_unsigned = (f3 == 3'd3);
            r.dec.is_imm = 1'b1;
            r.dec.imm = i_imm;
        end
        7'h33: begin
            if (f7 == 7'h00) r.dec.alu_op = alu_from_f3(f3);
            else if (f7 == 7'h20 && f3 == 3'd0) r.dec.alu_op = ALU_SUB;
            else if (f7 == 7'h20 && f3 == 3'd5) r.dec.alu_op = ALU_SRA;
            r.dec.is_unsigned = (f3 == 3'd3) && (f7 == 7'h00);
        end
        7'h1b: begin
            if (f3 == 3'd0) r.dec.alu_op = ALU_ADD;
            else if (f3 == 3'd1 && f7 == 7'h00) r.dec.alu_op = ALU_SLL;
            else if (f3 == 3'd5 && f7 == 7'h00) r.dec.alu_op = ALU_SRL;
            else if (f3 == 3'd5 && f7 == 7'h20) r.dec.alu_op = ALU_SRA;
            r.dec.is_imm = 1'b1;
            r.dec.imm = i_imm;
            r.dec.is_word = 1'b1;
        end
        7'h3b: begin
            if (f7 == 7'h00 && f3 == 3'd0) r.dec.alu_op = ALU_ADD;
            else if (f7 == 7'h20 && f3 == 3'd0) r.dec.alu_op = ALU_SUB;
            else if (f7 == 7'h00 && f3 == 3'd1) r.dec.alu_op = ALU_SLL;
            else if (f7 == 7'h00 && f3 == 3'd5) r.dec.alu_op = ALU_SRL;
            else if (f7 == 7'h20 && f3 == 3'd5) r.dec.alu_op = ALU_SRA;
            r.dec.is_word = 1'b1;
        end
        default: ;
    endcase
    // Writeback follows from a recognized operation, never from a branch or store
    r.dec.need_to_wb = r.dec.is_load || r.dec.alu_op != ALU_NONE ||
                       r.dec.cx_op == CX_JAL || r.dec.cx_op == CX_JALR;
    if (r.dec.alu_op == ALU_NONE && (inst[6:0] == 7'h13 || inst[6:0] == 7'h1b ||
                                     inst[6:0] == 7'h33 || inst[6:0] == 7'h3b)) begin
        r.dec.is_imm = 1'b0;
        r.dec.is_word = 1'b0;
        r.dec.is_unsigned = 1'b0;
        r.dec.imm = '0;
    end
    return r;
endfunction

`endif

/* tests/decoder_tb.sv */
`timescale 1ns/10ps
`include "decoder_params.svh"

module decoder_tb
    import decoder_pkg::*;
;

    `include "decoder_ref.svh"

    localparam int NUM_RANDOM = 200;
    localparam int DRAIN_CYCLES = 100;

    logic clock;
    logic reset;
    fetch_t fetch;
    logic fetch_valid;
    logic fetch_ready;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [63:0] rs1_data;
    logic [63:0] rs2_data;
    issue_t issue;
    logic issue_valid;
    logic issue_ready;

    issue_t exp_q[$];
    issue_t exp_head;
    logic exp_empty = 1'b1;
    logic [31:0] insts[$];
    logic random_mode = 1'b0;
    int total_insts = 0;
    int checks = 0;
    int errors = 0;

    decoder_top DUT (.*);

    assign rs1_data = reg_value(rs1);
    assign rs2_data = reg_value(rs2);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // The scoreboard pops on every issue handshake, then records accepted fetches
    always @(posedge clock) begin
        if (!reset) begin
            if (issue_valid && issue_ready) begin
                checks++;
                if (exp_q.size() != 0) void'(exp_q.pop_front());
            end
            if (fetch_valid && fetch_ready) exp_q.push_back(ref_decode(fetch.inst, fetch.pc));
        end
    end

    always @(negedge clock) begin
        exp_empty = (exp_q.size() == 0);
        if (!exp_empty) exp_head = exp_q[0];
    end

    a_issue_match: assert property (@(posedge clock) disable iff (reset)
        issue_valid && issue_ready && !exp_empty |-> issue == exp_head)
        else begin
            errors++;
            $display("Error at %0t: issue expected %h actual %h", $time, exp_head, issue);
        end

    a_no_extra: assert property (@(posedge clock) disable iff (reset)
        issue_valid && issue_ready |-> !exp_empty)
        else begin
            errors++;
            $display("An instruction was issued that was never fetched, at %0t", $time);
        end

    a_issue_hold: assert property (@(posedge clock) disable iff (reset)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue))
        else begin
            errors++;
            $display("The issue packet changed while stalled, at %0t", $time);
        end

    a_fetch_hold: assert property (@(posedge clock) disable iff (reset)
        fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch))
        else begin
            errors++;
            $display("The fetch packet changed while stalled, at %0t", $time);
        end

    a_reset_state: assert property (@(posedge clock) $fell(reset) |-> fetch_ready && !issue_valid)
        else begin
            errors++;
            $display("fetch_ready or issue_valid left the reset state too early, at %0t", $time);
        end

    // Random back-pressure only while the random test runs
    always @(negedge clock) begin
        issue_ready = random_mode ? ($urandom % 3 != 0) : 1'b1;
    end

    task automatic send(input logic [31:0] inst, input logic [47:0] pc);
        logic taken;
        if (random_mode) repeat ($urandom % 3) @(negedge clock);
        fetch.inst = inst;
        fetch.pc = pc;
        fetch_valid = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            taken = fetch_ready; // Stable at the falling edge
            @(negedge clock);
        end
        fetch_valid = 1'b0;
    endtask

    task automatic run_batch(input string name);
        int err_start;
        int chk_start;
        int drain;
        logic [47:0] pc;
        err_start = errors;
        chk_start = checks;
        pc = 48'h0000_8000_1000;
        while (insts.size() != 0) begin
            if (random_mode) pc = {16'($urandom), $urandom} & 48'hffff_ffff_fffc;
            send(insts.pop_front(), pc);
            pc = pc + 48'd4;
        end
        drain = 0;
        while ((exp_q.size() != 0 || issue_valid) && drain < DRAIN_CYCLES) begin
            @(negedge clock);
            drain++;
        end
        $display("%s: %0d issued, %0d errors", name, checks - chk_start, errors - err_start);
    endtask

    function automatic logic [31:0] random_inst();
        logic [6:0] ops[14];
        logic [6:0] op;
        logic [31:0] word;
        logic [6:0] f7_pick[3];
        ops = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23, 7'h13, 7'h33,
                7'h0f, 7'h73, 7'h1b, 7'h3b, 7'h7f};
        f7_pick = '{7'h00, 7'h20, 7'h01};
        op = ops[$urandom % 14];
        word = {$urandom} & 32'hffff_ff80;
        if (op == 7'h33 || op == 7'h3b || $urandom % 2 == 0) word[31:25] = f7_pick[$urandom % 3];
        return word | {25'd0, op};
    endfunction

    initial begin
        void'($urandom(89187));
        total_insts = 50 + NUM_RANDOM;
        reset = 1'b1;
        fetch = '0;
        fetch_valid = 1'b0;
        issue_ready = 1'b1;
        repeat (16) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);

        assert (fetch_ready && !issue_valid) else begin
            errors++;
            $display("Handshake outputs are not idle after reset");
        end
        $display("after_reset: done, %0d errors", errors);

        insts.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33));
        insts.push_back(enc_r(7'h20, 5'd4, 5'd5, 3'd0, 5'd6, 7'h33));
        insts.push_back(enc_r(7'h00, 5'd7, 5'd8, 3'd1, 5'd9, 7'h33));
        insts.push_back(enc_r(7'h20, 5'd10, 5'd11, 3'd5, 5'd12, 7'h33));
        insts.push_back(enc_r(7'h00, 5'd13, 5'd14, 3'd3, 5'd15, 7'h33));
        insts.push_back(enc_r(7'h00, 5'd0, 5'd31, 3'd7, 5'd1, 7'h33));
        insts.push_back(enc_r(7'h00, 5'd16, 5'd17, 3'd6, 5'd18, 7'h33));
        insts.push_back(enc_r(7'h00, 5'd19, 5'd20, 3'd2, 5'd21, 7'h33));
        insts.push_back(enc_r(7'h00, 5'd22, 5'd23, 3'd5, 5'd24, 7'h33));
        insts.push_back(enc_i(12'hff8, 5'd3, 3'd0, 5'd4, 7'h13));
        insts.push_back(enc_i(12'h03f, 5'd3, 3'd1, 5'd4, 7'h13));
        insts.push_back(enc_i(12'h43f, 5'd3, 3'd5, 5'd4, 7'h13));
        insts.push_back(enc_i(12'h020, 5'd6, 3'd5, 5'd7, 7'h13));
        insts.push_back(enc_i(12'h800, 5'd6, 3'd2, 5'd7, 7'h13));
        insts.push_back(enc_i(12'h123, 5'd6, 3'd3, 5'd7, 7'h13));
        insts.push_back(enc_i(12'h7ff, 5'd6, 3'd4, 5'd7, 7'h13));
        insts.push_back(enc_i(12'hf00, 5'd9, 3'd0, 5'd8, 7'h1b));
        insts.push_back(enc_i(12'h41f, 5'd9, 3'd5, 5'd8, 7'h1b));
        insts.push_back(enc_r(7'h20, 5'd2, 5'd3, 3'd0, 5'd4, 7'h3b));
        insts.push_back(enc_r(7'h00, 5'd2, 5'd3, 3'd1, 5'd4, 7'h3b));
        run_batch("alu_forms");

        for (int f3 = 0; f3 < 7; f3++) insts.push_back(enc_i(12'hffc, 5'd2, 3'(f3), 5'd5, 7'h03));
        for (int f3 = 0; f3 < 4; f3++) insts.push_back(enc_s(12'h804, 5'd7, 5'd2, 3'(f3)));
        run_batch("loads_stores");

        for (int f3 = 0; f3 < 8; f3++) begin
            if (f3 != 2 && f3 != 3) insts.push_back(enc_b(13'h1ff0, 5'd1, 5'd2, 3'(f3)));
        end
        insts.push_back(enc_b(13'h0ffe, 5'd3, 5'd4, 3'd0));
        insts.push_back(enc_j(21'h1fff00, 5'd1));
        insts.push_back(enc_j(21'h0a5552, 5'd0));
        insts.push_back(enc_i(12'hf80, 5'd5, 3'd0, 5'd1, 7'h67));
        insts.push_back(enc_u(20'hfffff, 5'd10, 7'h37));
        insts.push_back(enc_u(20'h12345, 5'd11, 7'h17));
        run_batch("control_upper");

        insts.push_back(enc_r(7'h01, 5'd2, 5'd3, 3'd0, 5'd4, 7'h33));
        insts.push_back(enc_r(7'h01, 5'd2, 5'd3, 3'd4, 5'd4, 7'h33));
        insts.push_back(enc_r(7'h01, 5'd2, 5'd3, 3'd6, 5'd4, 7'h3b));
        insts.push_back(enc_i(12'h0ff, 5'd0, 3'd0, 5'd0, 7'h0f));
        insts.push_back(enc_i(12'h000, 5'd0, 3'd0, 5'd0, 7'h73));
        insts.push_back(32'hdeadbe_ff);
        run_batch("dropped_encodings");

        random_mode = 1'b1;
        for (int i = 0; i < NUM_RANDOM; i++) insts.push_back(random_inst());
        run_batch("back_pressure");
        random_mode = 1'b0;

        assert (exp_q.size() == 0) else begin
            errors++;
            $display("Scoreboard still holds %0d instructions", exp_q.size());
        end

        $display("Checks passed: %0d, failed: %0d", checks - errors, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the instruction count
    initial begin
        wait (total_insts != 0);
        repeat (total_insts * 40 + 200 + 16) @(posedge clock);
        $display("Run timed out before all instructions issued");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* hw/decoder_top.sv */
`timescale 1ns/10ps
`include "decoder_params.svh"

module decoder_top
    import decoder_pkg::*;
(
    input  logic                           clock,
    input  logic                           reset,
    input  fetch_t                         fetch,
    input  logic                           fetch_valid,
    output logic                           fetch_ready,
    output logic [`DEC_REG_ADDR_WIDTH-1:0] rs1,
    output logic [`DEC_REG_ADDR_WIDTH-1:0] rs2,
    input  logic [`DEC_XLEN-1:0]           rs1_data,
    input  logic [`DEC_XLEN-1:0]           rs2_data,
    output issue_t                         issue,
    output logic                           issue_valid,
    input  logic                           issue_ready
);

    decoded_t dec;
    logic dec_valid;
    logic dec_ready;
    decoded_t head;
    logic head_valid;
    logic head_ready;

    inst_decoder u_inst_decoder (
        .clock       (clock),
        .reset       (reset),
        .fetch       (fetch),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .dec         (dec),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready)
    );

    decode_queue u_decode_queue (
        .clock     (clock),
        .reset     (reset),
        .in        (dec),
        .in_valid  (dec_valid),
        .in_ready  (dec_ready),
        .out       (head),
        .out_valid (head_valid),
        .out_ready (head_ready)
    );

    operand_issue u_operand_issue (
        .clock       (clock),
        .reset       (reset),
        .head        (head),
        .head_valid  (head_valid),
        .head_ready  (head_ready),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .issue       (issue),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready)
    );

endmodule

/* hw/operand_issue.sv */
`timescale 1ns/10ps
`include "decoder_params.svh"

module operand_issue
    import decoder_pkg::*;
(
    input  logic                           clock,
    input  logic                           reset,
    input  decoded_t                       head,
    input  logic                           head_valid,
    output logic                           head_ready,
    output logic [`DEC_REG_ADDR_WIDTH-1:0] rs1,
    output logic [`DEC_REG_ADDR_WIDTH-1:0] rs2,
    input  logic [`DEC_XLEN-1:0]           rs1_data,
    input  logic [`DEC_XLEN-1:0]           rs2_data,
    output issue_t                         issue,
    output logic                           issue_valid,
    input  logic                           issue_ready
);

    assign rs1 = head.rs1; // Register file answers in the same cycle
    assign rs2 = head.rs2;

    assign head_ready = !issue_valid || issue_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else if (head_valid && head_ready) begin
            issue_valid <= 1'b1;
        end else if (issue_ready) begin
            issue_valid <= 1'b0;
        end
    end

    // x0 data is taken as the register file returns it
    always_ff @(posedge clock) begin
        if (head_valid && head_ready) begin
            issue.dec  <= head;
            issue.src1 <= rs1_data;
            issue.src2 <= rs2_data;
        end
    end

    a_issue_stable: assert property (@(posedge clock) disable iff (reset)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue));

endmodule

/* hw/decode_queue.sv */
`timescale 1ns/10ps
`include "decoder_params.svh"

module decode_queue
    import decoder_pkg::*;
#(
    parameter int DEPTH = `DEC_QUEUE_DEPTH
) (
    input  logic     clock,
    input  logic     reset,
    input  decoded_t in,
    input  logic     in_valid,
    output logic     in_ready,
    output decoded_t out,
    output logic     out_valid,
    input  logic     out_ready
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    decoded_t mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic push;
    logic pop;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out       = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap explicitly so DEPTH need not be a power of two
            if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) mem[wr_ptr] <= in;
    end

    a_count_max: assert property (@(posedge clock) disable iff (reset) count <= CNT_W'(DEPTH));

    // A read request on an empty queue must not move the read side
    a_no_empty_pop: assert property (@(posedge clock) disable iff (reset)
        out_ready && count == '0 |=> $stable(rd_ptr));

endmodule

/* hw/inst_decoder.sv */
`timescale 1ns/10ps
`include "decoder_params.svh"

module inst_decoder
    import decoder_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  fetch_t   fetch,
    input  logic     fetch_valid,
    output logic     fetch_ready,
    output decoded_t dec,
    output logic     dec_valid,
    input  logic     dec_ready
);

    opcode_e opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    imm_fmt_e fmt;
    logic [`DEC_XLEN-1:0] imm;
    decoded_t ctrl;
    decoded_t dec_d;

    assign opcode = opcode_e'(fetch.inst[6:0]);
    assign funct3 = fetch.inst[14:12];
    assign funct7 = fetch.inst[31:25];

    imm_gen u_imm_gen (
        .inst (fetch.inst),
        .fmt  (fmt),
        .imm  (imm)
    );

    always_comb begin
        ctrl     = '0; // All control fields inactive unless a legal encoding sets them
        fmt      = IMM_NONE;
        ctrl.pc  = fetch.pc;
        ctrl.rd  = fetch.inst[11:7];
        ctrl.rs1 = fetch.inst[19:15];
        ctrl.rs2 = fetch.inst[24:20];
        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                ctrl.alu_op     = (opcode == OPC_LUI) ? ALU_LUI : ALU_AUIPC;
                ctrl.need_to_wb = 1'b1;
                fmt             = IMM_U;
            end
            OPC_JAL, OPC_JALR: begin
                ctrl.cx_op      = (opcode == OPC_JAL) ? CX_JAL : CX_JALR;
                ctrl.need_to_wb = 1'b1;
                fmt             = (opcode == OPC_JAL) ? IMM_J : IMM_I;
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  ctrl.cx_op = CX_BEQ;
                    3'b001:  ctrl.cx_op = CX_BNE;
                    3'b100,
                    3'b110:  ctrl.cx_op = CX_BLT;
                    3'b101,
                    3'b111:  ctrl.cx_op = CX_BGE;
                    default: ctrl.cx_op = CX_NONE;
                endcase
                if (ctrl.cx_op != CX_NONE) begin
                    ctrl.is_unsigned = funct3[1]; // BLTU and BGEU
                    fmt              = IMM_B;
                end
            end
            OPC_LOAD: begin
                if (funct3 != 3'b111) begin
                    ctrl.is_load     = 1'b1;
                    ctrl.need_to_wb  = 1'b1;
                    ctrl.ls_size     = ls_size_e'(funct3[1:0]);
                    ctrl.is_unsigned = funct3[2]; // LBU, LHU and LWU
                    fmt              = IMM_I;
                end
            end
            OPC_STORE: begin
                if (!funct3[2]) begin
                    ctrl.is_store = 1'b1;
                    ctrl.ls_size  = ls_size_e'(funct3[1:0]);
                    fmt           = IMM_S;
                end
            end
            OPC_OP_IMM: begin
                // funct7[0] carries shamt[5] for the 64-bit shifts
                case (funct3)
                    3'b000: ctrl.alu_op = ALU_ADD;
                    3'b010: ctrl.alu_op = ALU_SLT;
                    3'b011: begin
                        ctrl.alu_op      = ALU_SLT;
                        ctrl.is_unsigned = 1'b1;
                    end
                    3'b100: ctrl.alu_op = ALU_XOR;
                    3'b110: ctrl.alu_op = ALU_OR;
                    3'b111: ctrl.alu_op = ALU_AND;
                    3'b001: if (funct7[6:1] == 6'b000000) ctrl.alu_op = ALU_SLL;
                    default: begin
                        if (funct7[6:1] == 6'b000000) ctrl.alu_op = ALU_SRL;
                        if (funct7[6:1] == 6'b010000) ctrl.alu_op = ALU_SRA;
                    end
                endcase
                if (ctrl.alu_op != ALU_NONE) begin
                    ctrl.is_imm     = 1'b1;
                    ctrl.need_to_wb = 1'b1;
                    fmt             = IMM_I;
                end
            end
            OPC_OP: begin
                case ({funct7, funct3})
                    10'b0000000_000: ctrl.alu_op = ALU_ADD;
                    10'b0100000_000: ctrl.alu_op = ALU_SUB;
                    10'b0000000_001: ctrl.alu_op = ALU_SLL;
                    10'b0000000_010: ctrl.alu_op = ALU_SLT;
                    10'b0000000_011: begin
                        ctrl.alu_op      = ALU_SLT;
                        ctrl.is_unsigned = 1'b1;
                    end
                    10'b0000000_100: ctrl.alu_op = ALU_XOR;
                    10'b0000000_101: ctrl.alu_op = ALU_SRL;
                    10'b0100000_101: ctrl.alu_op = ALU_SRA;
                    10'b0000000_110: ctrl.alu_op = ALU_OR;
                    10'b0000000_111: ctrl.alu_op = ALU_AND;
                    default:         ctrl.alu_op = ALU_NONE; // Also MUL, DIV and REM
                endcase
                ctrl.need_to_wb = (ctrl.alu_op != ALU_NONE);
            end
            OPC_OP_IMM_32, OPC_OP_32: begin
                case ({funct7, funct3})
                    10'b0000000_000: ctrl.alu_op = ALU_ADD;
                    10'b0100000_000: ctrl.alu_op = (opcode == OPC_OP_32) ? ALU_SUB : ALU_ADD;
                    10'b0000000_001: ctrl.alu_op = ALU_SLL;
                    10'b0000000_101: ctrl.alu_op = ALU_SRL;
                    10'b0100000_101: ctrl.alu_op = ALU_SRA;
                    default: begin
                        // ADDIW takes any upper immediate bits
                        if (opcode == OPC_OP_IMM_32 && funct3 == 3'b000) ctrl.alu_op = ALU_ADD;
                    end
                endcase
                if (ctrl.alu_op != ALU_NONE) begin
                    ctrl.is_word    = 1'b1;
                    ctrl.need_to_wb = 1'b1;
                    ctrl.is_imm     = (opcode == OPC_OP_IMM_32);
                    fmt             = (opcode == OPC_OP_IMM_32) ? IMM_I : IMM_NONE;
                end
            end
            OPC_MISC_MEM, OPC_SYSTEM: ;  // FENCE and ENV issue as no-ops
            default: ;
        endcase
    end

    always_comb begin
        dec_d     = ctrl;
        dec_d.imm = imm;
    end

    assign fetch_ready = !dec_valid || dec_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (fetch_valid && fetch_ready) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (fetch_valid && fetch_ready) dec <= dec_d;
    end

    // A stalled packet must reach the queue unchanged
    a_dec_stable: assert property (@(posedge clock) disable iff (reset)
        dec_valid && !dec_ready |=> dec_valid && $stable(dec));

endmodule

/* hw/imm_gen.sv */
`timescale 1ns/10ps
`include "decoder_params.svh"

module imm_gen
    import decoder_pkg::*;
(
    input  logic [`DEC_INST_WIDTH-1:0] inst,
    input  imm_fmt_e                   fmt,
    output logic [`DEC_XLEN-1:0]       imm
);

    logic sign;
    logic [11:0] imm_i;
    logic [11:0] imm_s;
    logic [12:0] imm_b;
    logic [31:0] imm_u;
    logic [20:0] imm_j;

    // Every format keeps its sign in bit 31 of the instruction
    assign sign  = inst[31];
    assign imm_i = inst[31:20];
    assign imm_s = {inst[31:25], inst[11:7]};
    assign imm_b = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (fmt)
            IMM_I:   imm = {{(`DEC_XLEN-12){sign}}, imm_i};
            IMM_S:   imm = {{(`DEC_XLEN-12){sign}}, imm_s};
            IMM_B:   imm = {{(`DEC_XLEN-13){sign}}, imm_b};
            IMM_U:   imm = {{(`DEC_XLEN-32){sign}}, imm_u};
            IMM_J:   imm = {{(`DEC_XLEN-21){sign}}, imm_j};
            default: imm = '0; // No immediate for R-type and dropped encodings
        endcase
    end

endmodule

/* hw/decoder_pkg.sv */
package decoder_pkg;

`include "decoder_params.svh"

    // Major opcodes of the RV64I base set
    typedef enum logic [6:0] {
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_BRANCH    = 7'b1100011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP        = 7'b0110011,
        OPC_MISC_MEM  = 7'b0001111,
        OPC_SYSTEM    = 7'b1110011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_OP_32     = 7'b0111011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    // Unsigned branch compares reuse BLT and BGE with is_unsigned
    typedef enum logic [2:0] {
        CX_NONE, CX_JAL, CX_JALR, CX_BEQ, CX_BNE, CX_BLT, CX_BGE
    } cx_op_e;

    typedef enum logic [1:0] {
        LS_BYTE, LS_HALF, LS_WORD, LS_DOUBLE // Matches funct3[1:0] of loads and stores
    } ls_size_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_fmt_e;

    typedef struct packed {
        logic [`DEC_INST_WIDTH-1:0] inst;
        logic [`DEC_PC_WIDTH-1:0]   pc;
    } fetch_t;

    typedef struct packed {
        logic [`DEC_PC_WIDTH-1:0]       pc;
        logic [`DEC_REG_ADDR_WIDTH-1:0] rd;
        logic [`DEC_REG_ADDR_WIDTH-1:0] rs1;
        logic [`DEC_REG_ADDR_WIDTH-1:0] rs2;
        logic [`DEC_XLEN-1:0]           imm;
        alu_op_e                        alu_op;
        cx_op_e                         cx_op;
        ls_size_e                       ls_size;
        logic                           need_to_wb;
        logic                           is_unsigned;
        logic                           is_word;
        logic                           is_imm;
        logic                           is_load;
        logic                           is_store;
    } decoded_t;

    typedef struct packed {
        decoded_t             dec;
        logic [`DEC_XLEN-1:0] src1;
        logic [`DEC_XLEN-1:0] src2;
    } issue_t;

endpackage

/* hw/decoder_params.svh */
`ifndef DECODER_PARAMS_SVH
`define DECODER_PARAMS_SVH

// Data path and immediate width
`define DEC_XLEN 64

`define DEC_PC_WIDTH 48
`define DEC_INST_WIDTH 32
`define DEC_REG_ADDR_WIDTH 5

// Entries in the decode queue between decoder and issue stage
`define DEC_QUEUE_DEPTH 4

`endif
